//--- Makefile
VERILATOR  ?= verilator
TOP        := axil_mem_subsys_tb
FILELIST   := axil_mem_subsys.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := RESULT: PASS
LINT_FLAGS := --lint-only --timing --assert
VFLAGS     := --binary --timing --assert -j 0
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- axil_mem_subsys.f
design/axil_pkg.sv
design/axil_fifo.sv
design/axil_fifo_master.sv
design/axil_mem_slave.sv
design/axil_mem_subsys.sv
verif/axil_mem_subsys_sva.sv
verif/axil_mem_subsys_checker.sv
verif/axil_mem_subsys_tb.sv

//--- design/axil_fifo.sv
`timescale 1ns/10ps

module axil_fifo #(
  parameter int width_p = 8
  , parameter int els_p = 4
) (
  input  logic               clk_i
  , input  logic               arst_n_i

  , input  logic [width_p-1:0] data_i
  , input  logic               v_i
  , output logic               ready_o

  , output logic [width_p-1:0] data_o
  , output logic               v_o
  , input  logic               yumi_i
);

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  typedef logic [ptr_width_lp-1:0] ptr_t;
  typedef logic [cnt_width_lp-1:0] cnt_t;
  typedef logic [width_p-1:0]      entry_t;

  entry_t mem_q [els_p];
  ptr_t   rd_ptr_q, wr_ptr_q;
  cnt_t   count_q, count_n;
  logic   ready_q;
  logic   enq, deq;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(els_p - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign enq = v_i & ready_q;
  assign deq = yumi_i & v_o;

  assign count_n = count_q + cnt_t'(enq) - cnt_t'(deq);

  assign ready_o = ready_q;  // Low while in reset.
  assign v_o     = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (enq) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (deq) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_n;
      ready_q <= (count_n != cnt_t'(els_p));
    end
  end

  // Entry storage.
  always_ff @(posedge clk_i) begin
    if (enq) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- design/axil_fifo_master.sv
`timescale 1ns/10ps

module axil_fifo_master #(
  parameter int axil_data_width_p = 32
  , parameter int axil_addr_width_p = 12
  , parameter int fifo_els_p = 4
  , localparam int mask_width_lp = axil_data_width_p / 8
) (
  input  logic                         clk_i
  , input  logic                         arst_n_i

  // Client command stream.
  , input  logic [axil_data_width_p-1:0] data_i
  , input  logic [axil_addr_width_p-1:0] addr_i
  , input  logic                         v_i
  , input  logic                         w_i
  , input  logic [mask_width_lp-1:0]     wmask_i
  , output logic                         ready_and_o

  // Client response stream.
  , output logic [axil_data_width_p-1:0] data_o
  , output logic                         v_o
  , input  logic                         ready_and_i

  , output logic [axil_addr_width_p-1:0] m_axil_awaddr_o
  , output axil_pkg::axil_prot_t         m_axil_awprot_o
  , output logic                         m_axil_awvalid_o
  , input  logic                         m_axil_awready_i

  , output logic [axil_data_width_p-1:0] m_axil_wdata_o
  , output logic [mask_width_lp-1:0]     m_axil_wstrb_o
  , output logic                         m_axil_wvalid_o
  , input  logic                         m_axil_wready_i

  , input  axil_pkg::axil_resp_t         m_axil_bresp_i
  , input  logic                         m_axil_bvalid_i
  , output logic                         m_axil_bready_o

  , output logic [axil_addr_width_p-1:0] m_axil_araddr_o
  , output axil_pkg::axil_prot_t         m_axil_arprot_o
  , output logic                         m_axil_arvalid_o
  , input  logic                         m_axil_arready_i

  , input  logic [axil_data_width_p-1:0] m_axil_rdata_i
  , input  axil_pkg::axil_resp_t         m_axil_rresp_i
  , input  logic                         m_axil_rvalid_i
  , output logic                         m_axil_rready_o
);

  import axil_pkg::*;

  typedef logic [axil_addr_width_p-1:0] addr_t;

  logic  accept;
  logic  wdata_ready_lo, addr_ready_lo, return_ready_lo;
  logic  addr_w_lo, addr_v_lo, addr_yumi_li;
  addr_t addr_lo;
  logic  return_w_lo, return_v_lo, return_yumi_li;

  // All three queues need room.
  assign ready_and_o = wdata_ready_lo & addr_ready_lo & return_ready_lo;
  assign accept      = v_i & ready_and_o;

  axil_fifo #(
    .width_p(axil_data_width_p + mask_width_lp)
    , .els_p(fifo_els_p)
  ) wdata_fifo (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .data_i({data_i, wmask_i})
    , .v_i(accept & w_i)  // Writes only.
    , .ready_o(wdata_ready_lo)
    , .data_o({m_axil_wdata_o, m_axil_wstrb_o})
    , .v_o(m_axil_wvalid_o)
    , .yumi_i(m_axil_wready_i & m_axil_wvalid_o)
  );

  axil_fifo #(
    .width_p(1 + axil_addr_width_p)
    , .els_p(fifo_els_p)
  ) addr_fifo (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .data_i({w_i, addr_i})
    , .v_i(accept)
    , .ready_o(addr_ready_lo)
    , .data_o({addr_w_lo, addr_lo})
    , .v_o(addr_v_lo)
    , .yumi_i(addr_yumi_li)
  );

  // Kind of every command, oldest first.
  axil_fifo #(
    .width_p(1)
    , .els_p(fifo_els_p)
  ) return_fifo (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .data_i(w_i)
    , .v_i(accept)
    , .ready_o(return_ready_lo)
    , .data_o(return_w_lo)
    , .v_o(return_v_lo)
    , .yumi_i(return_yumi_li)
  );

  // Oldest address goes to AW or AR by its kind bit.
  assign m_axil_awvalid_o = addr_v_lo & addr_w_lo;
  assign m_axil_awaddr_o  = addr_lo;
  assign m_axil_awprot_o  = axil_prot_data_c;

  assign m_axil_arvalid_o = addr_v_lo & ~addr_w_lo;
  assign m_axil_araddr_o  = addr_lo;
  assign m_axil_arprot_o  = axil_prot_data_c;

  assign addr_yumi_li = (m_axil_awvalid_o & m_axil_awready_i)
                      | (m_axil_arvalid_o & m_axil_arready_i);

  assign v_o    = return_v_lo & (return_w_lo ? m_axil_bvalid_i : m_axil_rvalid_i);
  assign data_o = m_axil_rdata_i;  // Don't care for writes.

  assign m_axil_bready_o = return_v_lo & return_w_lo & ready_and_i;
  assign m_axil_rready_o = return_v_lo & ~return_w_lo & ready_and_i;

  assign return_yumi_li = v_o & ready_and_i;

endmodule

//--- design/axil_mem_slave.sv
`timescale 1ns/10ps

module axil_mem_slave #(
  parameter int axil_data_width_p = 32
  , parameter int axil_addr_width_p = 12
  , parameter int mem_words_p = 16
  , localparam int mask_width_lp = axil_data_width_p / 8
) (
  input  logic                         clk_i
  , input  logic                         arst_n_i

  , input  logic [axil_addr_width_p-1:0] s_axil_awaddr_i
  , input  axil_pkg::axil_prot_t         s_axil_awprot_i
  , input  logic                         s_axil_awvalid_i
  , output logic                         s_axil_awready_o

  , input  logic [axil_data_width_p-1:0] s_axil_wdata_i
  , input  logic [mask_width_lp-1:0]     s_axil_wstrb_i
  , input  logic                         s_axil_wvalid_i
  , output logic                         s_axil_wready_o

  , output axil_pkg::axil_resp_t         s_axil_bresp_o
  , output logic                         s_axil_bvalid_o
  , input  logic                         s_axil_bready_i

  , input  logic [axil_addr_width_p-1:0] s_axil_araddr_i
  , input  axil_pkg::axil_prot_t         s_axil_arprot_i
  , input  logic                         s_axil_arvalid_i
  , output logic                         s_axil_arready_o

  , output logic [axil_data_width_p-1:0] s_axil_rdata_o
  , output axil_pkg::axil_resp_t         s_axil_rresp_o
  , output logic                         s_axil_rvalid_o
  , input  logic                         s_axil_rready_i
);

  import axil_pkg::*;

  localparam int idx_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  typedef logic [axil_data_width_p-1:0] word_t;
  typedef logic [axil_addr_width_p-1:0] addr_t;
  typedef logic [idx_width_lp-1:0]      idx_t;

  mem_slave_state_e state_q, state_n;
  word_t            mem_q [mem_words_p];
  word_t            rdata_q;
  logic             write_take, read_take;
  idx_t             widx, ridx;

  // Byte address to word, upper bits alias.
  function automatic idx_t word_index(addr_t addr);
    return idx_t'((addr / addr_t'(mask_width_lp)) % addr_t'(mem_words_p));
  endfunction

  assign widx = word_index(s_axil_awaddr_i);
  assign ridx = word_index(s_axil_araddr_i);

  // Writes win in idle.
  assign write_take = (state_q == e_slave_idle) & s_axil_awvalid_i & s_axil_wvalid_i;
  assign read_take  = (state_q == e_slave_idle) & s_axil_arvalid_i & ~write_take;

  assign s_axil_awready_o = write_take;
  assign s_axil_wready_o  = write_take;
  assign s_axil_arready_o = read_take;

  assign s_axil_bvalid_o = (state_q == e_slave_wresp);
  assign s_axil_bresp_o  = axil_resp_okay_c;
  assign s_axil_rvalid_o = (state_q == e_slave_rresp);
  assign s_axil_rresp_o  = axil_resp_okay_c;
  assign s_axil_rdata_o  = rdata_q;

  always_comb begin
    state_n = state_q;
    case (state_q)
      e_slave_idle: begin
        if (write_take) state_n = e_slave_wresp;
        else if (read_take) state_n = e_slave_rresp;
      end
      e_slave_wresp: if (s_axil_bready_i) state_n = e_slave_idle;
      e_slave_rresp: if (s_axil_rready_i) state_n = e_slave_idle;
      default: state_n = e_slave_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= e_slave_idle;
    else state_q <= state_n;
  end

  // Memory comes up zeroed.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < mem_words_p; i++)
        mem_q[i] <= '0;
    end else if (write_take) begin
      for (int b = 0; b < mask_width_lp; b++)
        if (s_axil_wstrb_i[b]) mem_q[widx][b*8 +: 8] <= s_axil_wdata_i[b*8 +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_take) rdata_q <= mem_q[ridx];  // Held until rready.
  end

endmodule

//--- design/axil_mem_subsys.sv
`timescale 1ns/10ps

module axil_mem_subsys #(
  parameter int axil_data_width_p = axil_pkg::axil_data_width_c
  , parameter int axil_addr_width_p = axil_pkg::axil_addr_width_c
  , parameter int fifo_els_p = axil_pkg::fifo_els_c
  , parameter int mem_words_p = axil_pkg::mem_words_c
  , localparam int mask_width_lp = axil_data_width_p / 8
) (
  input  logic                         clk_i
  , input  logic                         arst_n_i

  , input  logic [axil_data_width_p-1:0] data_i
  , input  logic [axil_addr_width_p-1:0] addr_i
  , input  logic                         v_i
  , input  logic                         w_i
  , input  logic [mask_width_lp-1:0]     wmask_i
  , output logic                         ready_and_o

  , output logic [axil_data_width_p-1:0] data_o
  , output logic                         v_o
  , input  logic                         ready_and_i
);

  import axil_pkg::*;

  typedef logic [axil_data_width_p-1:0] word_t;
  typedef logic [axil_addr_width_p-1:0] addr_t;
  typedef logic [mask_width_lp-1:0]     mask_t;

  addr_t      awaddr, araddr;
  axil_prot_t awprot, arprot;
  logic       awvalid, awready, arvalid, arready;
  word_t      wdata, rdata;
  mask_t      wstrb;
  logic       wvalid, wready;
  axil_resp_t bresp, rresp;
  logic       bvalid, bready, rvalid, rready;

  axil_fifo_master #(
    .axil_data_width_p(axil_data_width_p)
    , .axil_addr_width_p(axil_addr_width_p)
    , .fifo_els_p(fifo_els_p)
  ) u_master (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .data_i(data_i)
    , .addr_i(addr_i)
    , .v_i(v_i)
    , .w_i(w_i)
    , .wmask_i(wmask_i)
    , .ready_and_o(ready_and_o)
    , .data_o(data_o)
    , .v_o(v_o)
    , .ready_and_i(ready_and_i)
    , .m_axil_awaddr_o(awaddr)
    , .m_axil_awprot_o(awprot)
    , .m_axil_awvalid_o(awvalid)
    , .m_axil_awready_i(awready)
    , .m_axil_wdata_o(wdata)
    , .m_axil_wstrb_o(wstrb)
    , .m_axil_wvalid_o(wvalid)
    , .m_axil_wready_i(wready)
    , .m_axil_bresp_i(bresp)
    , .m_axil_bvalid_i(bvalid)
    , .m_axil_bready_o(bready)
    , .m_axil_araddr_o(araddr)
    , .m_axil_arprot_o(arprot)
    , .m_axil_arvalid_o(arvalid)
    , .m_axil_arready_i(arready)
    , .m_axil_rdata_i(rdata)
    , .m_axil_rresp_i(rresp)
    , .m_axil_rvalid_i(rvalid)
    , .m_axil_rready_o(rready)
  );

  axil_mem_slave #(
    .axil_data_width_p(axil_data_width_p)
    , .axil_addr_width_p(axil_addr_width_p)
    , .mem_words_p(mem_words_p)
  ) u_slave (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .s_axil_awaddr_i(awaddr)
    , .s_axil_awprot_i(awprot)
    , .s_axil_awvalid_i(awvalid)
    , .s_axil_awready_o(awready)
    , .s_axil_wdata_i(wdata)
    , .s_axil_wstrb_i(wstrb)
    , .s_axil_wvalid_i(wvalid)
    , .s_axil_wready_o(wready)
    , .s_axil_bresp_o(bresp)
    , .s_axil_bvalid_o(bvalid)
    , .s_axil_bready_i(bready)
    , .s_axil_araddr_i(araddr)
    , .s_axil_arprot_i(arprot)
    , .s_axil_arvalid_i(arvalid)
    , .s_axil_arready_o(arready)
    , .s_axil_rdata_o(rdata)
    , .s_axil_rresp_o(rresp)
    , .s_axil_rvalid_o(rvalid)
    , .s_axil_rready_i(rready)
  );

endmodule

//--- design/axil_pkg.sv
package axil_pkg;

  // Defaults for the top level parameters.
  localparam int axil_data_width_c = 32;
  localparam int axil_addr_width_c = 12;
  localparam int fifo_els_c        = 4;  // Commands in flight.
  localparam int mem_words_c       = 16;

  typedef logic [1:0] axil_resp_t;
  typedef logic [2:0] axil_prot_t;

  localparam axil_resp_t axil_resp_okay_c = 2'b00;

  // Unprivileged, secure, data access.
  localparam axil_prot_t axil_prot_data_c = 3'b000;

  // Memory slave serves one transaction at a time.
  typedef enum logic [1:0] {
    e_slave_idle,
    e_slave_wresp,  // Holding bvalid.
    e_slave_rresp   // Holding rvalid.
  } mem_slave_state_e;

endpackage

//--- verif/axil_mem_subsys_checker.sv
`timescale 1ns/10ps

module axil_mem_subsys_checker #(
  parameter int data_width_p = 32
  , parameter int addr_width_p = 12
  , parameter int mem_words_p = 16
) (
  input  logic                      clk_i
  , input  logic                      arst_n_i
  , input  logic [data_width_p-1:0]   cmd_data_i
  , input  logic [addr_width_p-1:0]   cmd_addr_i
  , input  logic                      cmd_w_i
  , input  logic [data_width_p/8-1:0] cmd_mask_i
  , input  logic                      cmd_v_i
  , input  logic                      cmd_ready_i
  , input  logic [data_width_p-1:0]   exp_data_i  // Table value, used when exp_v_i.
  , input  logic                      exp_v_i
  , input  logic [data_width_p-1:0]   resp_data_i
  , input  logic                      resp_v_i
  , input  logic                      resp_ready_i
  , input  int                        test_num_i
  , input  logic                      test_done_i
  , output int                        resp_cnt_o
  , output int                        check_cnt_o
  , output int                        err_cnt_o
);

  localparam int bytes_lp = data_width_p / 8;

  logic [data_width_p-1:0] shadow [mem_words_p];
  logic                    kind_q [$];  // One per accepted command, oldest first.
  logic [data_width_p-1:0] exp_q [$];
  int resp_cnt = 0;
  int check_cnt = 0;
  int err_cnt = 0;
  int test_checks = 0;
  int test_errs = 0;

  assign resp_cnt_o  = resp_cnt;
  assign check_cnt_o = check_cnt;
  assign err_cnt_o   = err_cnt;

  always @(posedge clk_i) begin
    int idx;
    logic is_w;
    logic [data_width_p-1:0] exp_word;
    if (!arst_n_i) begin
      foreach (shadow[i]) shadow[i] = '0;
      kind_q.delete();
      exp_q.delete();
    end else begin
      if (resp_v_i && resp_ready_i) begin
        if (kind_q.size() == 0) begin
          $display("Response at %0t arrived with no command outstanding", $time);
          err_cnt++;
          test_errs++;
        end else begin
          is_w = kind_q.pop_front();
          exp_word = exp_q.pop_front();
          resp_cnt++;
          if (!is_w) begin
            check_cnt++;
            test_checks++;
            if (resp_data_i !== exp_word) begin
              $display("[FAIL] t=%0t data_o expected 0x%h actual 0x%h",
                       $time, exp_word, resp_data_i);
              err_cnt++;
              test_errs++;
            end
          end
        end
      end
      if (cmd_v_i && cmd_ready_i) begin
        idx = (int'(cmd_addr_i) / bytes_lp) % mem_words_p;  // High bits alias.
        if (cmd_w_i) begin
          for (int b = 0; b < bytes_lp; b++)
            if (cmd_mask_i[b]) shadow[idx][b*8 +: 8] = cmd_data_i[b*8 +: 8];
        end
        kind_q.push_back(cmd_w_i);
        exp_q.push_back(exp_v_i ? exp_data_i : shadow[idx]);
      end
      if (test_done_i) begin
        $display("test %0d finished: %0d reads checked, %0d errors",
                 test_num_i, test_checks, test_errs);
        test_checks = 0;
        test_errs = 0;
      end
    end
  end

endmodule

//--- verif/axil_mem_subsys_sva.sv
`timescale 1ns/10ps

module axil_mem_subsys_sva #(
  parameter int axil_data_width_p = 32
  , parameter int axil_addr_width_p = 12
) (
  input  logic                           clk_i
  , input  logic                           arst_n_i
  , input  logic [axil_addr_width_p-1:0]   awaddr_i
  , input  logic                           awvalid_i
  , input  logic                           awready_i
  , input  logic [axil_data_width_p-1:0]   wdata_i
  , input  logic [axil_data_width_p/8-1:0] wstrb_i
  , input  logic                           wvalid_i
  , input  logic                           wready_i
  , input  logic [axil_addr_width_p-1:0]   araddr_i
  , input  logic                           arvalid_i
  , input  logic                           arready_i
  , input  logic                           resp_v_i
);

  int fail_cnt = 0;  // Read by the testbench at the end.

  aw_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else begin
      fail_cnt++;
      $error("AW dropped or changed while stalled.");
    end

  // Data and strobes move together.
  w_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else begin
      fail_cnt++;
      $error("W dropped or changed while stalled.");
    end

  ar_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
      fail_cnt++;
      $error("AR dropped or changed while stalled.");
    end

  resp_quiet_a: assert property (@(posedge clk_i) !arst_n_i |-> !resp_v_i)
    else begin
      fail_cnt++;
      $error("Client response valid during reset.");
    end

endmodule

bind axil_mem_subsys axil_mem_subsys_sva #(
  .axil_data_width_p(axil_data_width_p)
  , .axil_addr_width_p(axil_addr_width_p)
) sva_i (
  .clk_i(clk_i)
  , .arst_n_i(arst_n_i)
  , .awaddr_i(awaddr)
  , .awvalid_i(awvalid)
  , .awready_i(awready)
  , .wdata_i(wdata)
  , .wstrb_i(wstrb)
  , .wvalid_i(wvalid)
  , .wready_i(wready)
  , .araddr_i(araddr)
  , .arvalid_i(arvalid)
  , .arready_i(arready)
  , .resp_v_i(v_o)
);

//--- verif/axil_mem_subsys_tb.sv
`timescale 1ns/10ps

module axil_mem_subsys_tb;

  import axil_pkg::*;

  localparam int data_width_lp  = axil_data_width_c;
  localparam int addr_width_lp  = axil_addr_width_c;
  localparam int mask_width_lp  = data_width_lp / 8;
  localparam int wait_limit_lp  = 200;  // Cycles per wait.
  localparam int random_cmds_lp = 40;
  localparam int stall_test_lp  = 5;

  typedef logic [data_width_lp-1:0] word_t;
  typedef logic [addr_width_lp-1:0] addr_t;
  typedef logic [mask_width_lp-1:0] mask_t;

  typedef struct {
    int    test;
    logic  w;
    addr_t addr;
    word_t data;
    mask_t mask;
    logic  exp_v;
    word_t exp;
  } cmd_entry_t;

  logic clk_i = 1'b0;
  logic arst_n_i = 1'b1;
  logic ready_and_i = 1'b0;
  word_t data_i, data_o, exp_data;
  addr_t addr_i;
  mask_t wmask_i;
  logic v_i, w_i, exp_v, ready_and_o, v_o;
  logic test_done, pin_ready_low, timed_out;
  logic [15:0] lfsr_q;
  int test_num, sent_cnt, tests_run, tb_err_cnt;
  int resp_cnt, check_cnt, err_cnt;
  cmd_entry_t tbl [$];

  always #50 clk_i = ~clk_i;

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic void add_cmd(int test, logic w, addr_t addr, word_t data, mask_t mask,
                                  logic ev, word_t exp);
    cmd_entry_t c;
    c.test = test;
    c.w = w;
    c.addr = addr;
    c.data = data;
    c.mask = mask;
    c.exp_v = ev;
    c.exp = exp;
    tbl.push_back(c);
  endfunction

  function automatic void build_table();
    logic  w;
    addr_t a;
    word_t d;
    mask_t m;
    add_cmd(1, 1'b0, 12'h000, '0, '0, 1'b1, 32'h0000_0000);  // Fresh memory.
    add_cmd(1, 1'b0, 12'h024, '0, '0, 1'b1, 32'h0000_0000);
    add_cmd(1, 1'b0, 12'h03c, '0, '0, 1'b1, 32'h0000_0000);
    add_cmd(1, 1'b0, 12'hffc, '0, '0, 1'b1, 32'h0000_0000);
    add_cmd(2, 1'b1, 12'h008, 32'hdead_beef, 4'b1111, 1'b0, '0);
    add_cmd(2, 1'b0, 12'h008, '0, '0, 1'b1, 32'hdead_beef);
    add_cmd(3, 1'b1, 12'h008, 32'h1122_3344, 4'b0101, 1'b0, '0);
    add_cmd(3, 1'b0, 12'h008, '0, '0, 1'b1, 32'hde22_be44);
    add_cmd(3, 1'b1, 12'h00c, 32'ha5a5_a5a5, 4'b1000, 1'b0, '0);
    add_cmd(3, 1'b0, 12'h00c, '0, '0, 1'b1, 32'ha500_0000);
    add_cmd(4, 1'b1, 12'h110, 32'hcafe_f00d, 4'b1111, 1'b0, '0);  // Word 4 by alias.
    add_cmd(4, 1'b0, 12'h010, '0, '0, 1'b1, 32'hcafe_f00d);
    add_cmd(4, 1'b1, 12'h050, 32'h0000_0077, 4'b0001, 1'b0, '0);
    add_cmd(4, 1'b0, 12'hf90, '0, '0, 1'b1, 32'hcafe_f077);
    add_cmd(5, 1'b1, 12'h020, 32'h0102_0304, 4'b1111, 1'b0, '0);
    add_cmd(5, 1'b0, 12'h020, '0, '0, 1'b1, 32'h0102_0304);
    add_cmd(5, 1'b1, 12'h020, 32'hffff_ffff, 4'b0010, 1'b0, '0);
    add_cmd(5, 1'b0, 12'h020, '0, '0, 1'b1, 32'h0102_ff04);
    add_cmd(5, 1'b0, 12'h060, '0, '0, 1'b1, 32'h0102_ff04);  // After release.
    add_cmd(5, 1'b0, 12'h024, '0, '0, 1'b1, 32'h0000_0000);
    for (int n = 0; n < random_cmds_lp; n++) begin
      w = (take_bits(1) != 0);
      a = addr_t'(take_bits(addr_width_lp));
      d = word_t'(take_bits(data_width_lp));
      m = mask_t'(take_bits(mask_width_lp));
      add_cmd(6, w, a, d, m, 1'b0, '0);
    end
  endfunction

  // Response back-pressure.
  always @(negedge clk_i) begin
    if (!arst_n_i || pin_ready_low) ready_and_i = 1'b0;
    else ready_and_i = (take_bits(1) != 0);
  end

  task automatic send_cmd(cmd_entry_t c);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!ready_and_o && waited < wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ready_and_o) begin
      $display("Timeout at %0t: ready_and_o stayed low in test %0d", $time, c.test);
      timed_out = 1'b1;
    end else begin
      data_i = c.data;
      addr_i = c.addr;
      w_i = c.w;
      wmask_i = c.mask;
      exp_data = c.exp;
      exp_v = c.exp_v;
      v_i = 1'b1;
      sent_cnt++;
      @(negedge clk_i);
      v_i = 1'b0;
    end
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    while (resp_cnt != sent_cnt && waited < wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    if (resp_cnt != sent_cnt) begin
      $display("Timeout at %0t: only %0d of %0d responses arrived in test %0d",
               $time, resp_cnt, sent_cnt, test_num);
      timed_out = 1'b1;
    end else begin
      test_done = 1'b1;
      @(negedge clk_i);
      test_done = 1'b0;
      tests_run++;
    end
  endtask

  // Queues are full, so ready must stay low.
  task automatic check_stall();
    repeat (8) begin
      @(negedge clk_i);
      if (ready_and_o) begin
        $display("[FAIL] t=%0t ready_and_o expected 0 actual %b with %0d commands held",
                 $time, ready_and_o, fifo_els_c);
        tb_err_cnt++;
      end
    end
  endtask

  task automatic run_table();
    int test_sent;
    test_num = tbl[0].test;
    test_sent = 0;
    foreach (tbl[i]) begin
      if (tbl[i].test != test_num) begin
        finish_test();
        if (timed_out) return;
        test_num = tbl[i].test;
        test_sent = 0;
        if (test_num == stall_test_lp) begin
          @(posedge clk_i);
          pin_ready_low = 1'b1;
        end
      end
      if (pin_ready_low && test_sent == fifo_els_c) begin
        check_stall();
        @(posedge clk_i);
        pin_ready_low = 1'b0;
      end
      send_cmd(tbl[i]);
      if (timed_out) return;
      test_sent++;
    end
    finish_test();
  endtask

  axil_mem_subsys #(
    .axil_data_width_p(data_width_lp)
    , .axil_addr_width_p(addr_width_lp)
    , .fifo_els_p(fifo_els_c)
    , .mem_words_p(mem_words_c)
  ) axil_mem_subsys_i (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .data_i(data_i)
    , .addr_i(addr_i)
    , .v_i(v_i)
    , .w_i(w_i)
    , .wmask_i(wmask_i)
    , .ready_and_o(ready_and_o)
    , .data_o(data_o)
    , .v_o(v_o)
    , .ready_and_i(ready_and_i)
  );

  axil_mem_subsys_checker #(
    .data_width_p(data_width_lp)
    , .addr_width_p(addr_width_lp)
    , .mem_words_p(mem_words_c)
  ) resp_check_i (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .cmd_data_i(data_i)
    , .cmd_addr_i(addr_i)
    , .cmd_w_i(w_i)
    , .cmd_mask_i(wmask_i)
    , .cmd_v_i(v_i)
    , .cmd_ready_i(ready_and_o)
    , .exp_data_i(exp_data)
    , .exp_v_i(exp_v)
    , .resp_data_i(data_o)
    , .resp_v_i(v_o)
    , .resp_ready_i(ready_and_i)
    , .test_num_i(test_num)
    , .test_done_i(test_done)
    , .resp_cnt_o(resp_cnt)
    , .check_cnt_o(check_cnt)
    , .err_cnt_o(err_cnt)
  );

  initial begin
    int waited;
    int total_err;
    arst_n_i = 1'b0;  // Edge at time zero resets the DUT at once.
    data_i = '0;
    addr_i = '0;
    wmask_i = '0;
    v_i = 1'b0;
    w_i = 1'b0;
    exp_data = '0;
    exp_v = 1'b0;
    test_done = 1'b0;
    pin_ready_low = 1'b0;
    timed_out = 1'b0;
    test_num = 0;
    sent_cnt = 0;
    tests_run = 0;
    tb_err_cnt = 0;
    lfsr_q = 16'd29051;
    build_table();
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    if (v_o !== 1'b0) begin
      $display("[FAIL] t=%0t v_o expected 0 actual %b", $time, v_o);
      tb_err_cnt++;
    end
    waited = 0;
    while (!ready_and_o && waited < wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ready_and_o) begin
      $display("ready_and_o never rose after reset");
      timed_out = 1'b1;
    end else begin
      run_table();
    end
    total_err = err_cnt + tb_err_cnt + axil_mem_subsys_i.sva_i.fail_cnt;
    $display("%0d tests run, %0d reads checked, %0d errors", tests_run, check_cnt, total_err);
    if (timed_out || total_err != 0) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule
